// ==== Makefile ====
TOP := rob_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --top-module $(TOP) -f verilog.f --Mdir obj_dir -o rob_sim
	./obj_dir/rob_sim | tee $(LOG)
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== common/rob_pkg.sv ====
`include "rob_settings.svh"

package rob_pkg;

    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;
    typedef logic [`ROB_TAG_W:0]   rob_ptr_t;   // msb is the wrap bit
    typedef logic [`WORD_W-1:0]    word_t;
    typedef logic [`PC_W-1:0]      pc_t;
    typedef logic [`AREG_W-1:0]    areg_t;

    // exceptions known at decode
    typedef enum logic [2:0] {
        EXC_NONE            = 3'd0,
        EXC_ILLEGAL_INSN    = 3'd1,
        EXC_INSN_MISALIGNED = 3'd2,
        EXC_INSN_FAULT      = 3'd3
    } exc_code_e;

    typedef struct packed {
        logic      valid;
        pc_t       pc;
        areg_t     dst_addr;
        logic      dst_wen;
        exc_code_e exc;
    } alloc_req_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    data;
    } wb_pkt_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        logic     taken;
        pc_t      target;
    } br_res_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
    } store_done_t;

    typedef struct packed {
        logic      busy;
        pc_t       pc;
        areg_t     dst_addr;
        logic      dst_wen;
        word_t     value;
        logic      value_ready;
        logic      store_done;
        logic      br_done;
        logic      br_taken;
        pc_t       br_target;
        exc_code_e exc;
    } rob_entry_t;

    typedef struct packed {
        logic      valid;
        rob_tag_t  tag;
        pc_t       pc;
        areg_t     dst_addr;
        logic      dst_wen;
        word_t     value;
        logic      redirect;
        pc_t       redirect_pc;
        exc_code_e exc;
    } commit_t;

    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
    } opnd_req_t;

    typedef struct packed {
        logic  valid;
        word_t value;
    } opnd_rsp_t;

endpackage

// ==== common/rob_settings.svh ====
`ifndef ROB_SETTINGS_SVH
`define ROB_SETTINGS_SVH

// buffer geometry
`define ROB_DEPTH       16
`define ROB_TAG_W       4   // log2 of ROB_DEPTH

// datapath widths
`define WORD_W          32
`define PC_W            32
`define AREG_W          5

// identical writeback ports, index 0 has highest priority
`define NUM_WB_PORTS    3

`endif

// ==== hw/rob/rob_entry_array.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_entry_array
    import rob_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  alloc_req_t            alloc,
    input  logic                  alloc_fire,
    input  rob_tag_t              tail_tag,
    input  rob_tag_t              head_tag,
    input  wb_pkt_t               wb [`NUM_WB_PORTS],
    input  br_res_t               br,
    input  store_done_t           store_done,
    input  logic                  retire,
    input  logic                  flush,
    output rob_entry_t            head_entry,
    output word_t                 values [`ROB_DEPTH],
    output logic [`ROB_DEPTH-1:0] value_ready
);

    logic [`ROB_DEPTH-1:0] busy;
    logic [`ROB_DEPTH-1:0] st_done;
    logic [`ROB_DEPTH-1:0] br_done;

    pc_t       pc_q        [`ROB_DEPTH];
    areg_t     dst_addr_q  [`ROB_DEPTH];
    logic      dst_wen_q   [`ROB_DEPTH];
    exc_code_e exc_q       [`ROB_DEPTH];
    logic      br_taken_q  [`ROB_DEPTH];
    pc_t       br_target_q [`ROB_DEPTH];

    logic [`ROB_DEPTH-1:0] wb_hit;
    word_t                 wb_data [`ROB_DEPTH];

    // per entry port select, walk down so port 0 wins
    always_comb begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            wb_hit[i]  = 1'b0;
            wb_data[i] = '0;
            for (int p = `NUM_WB_PORTS - 1; p >= 0; p--) begin
                if (wb[p].valid && wb[p].tag == rob_tag_t'(i)) begin
                    wb_hit[i]  = 1'b1;
                    wb_data[i] = wb[p].data;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy        <= '0;
            value_ready <= '0;
            st_done     <= '0;
            br_done     <= '0;
        end else if (flush) begin
            busy        <= '0;
            value_ready <= '0;
            st_done     <= '0;
            br_done     <= '0;
        end else begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                if (alloc_fire && tail_tag == rob_tag_t'(i)) begin
                    busy[i]        <= 1'b1;
                    value_ready[i] <= 1'b0;
                    st_done[i]     <= 1'b0;
                    br_done[i]     <= 1'b0;
                end else if (retire && head_tag == rob_tag_t'(i)) begin
                    busy[i]        <= 1'b0;
                    value_ready[i] <= 1'b0;
                    st_done[i]     <= 1'b0;
                    br_done[i]     <= 1'b0;
                end else if (busy[i]) begin   // stale strobes after a flush are dropped
                    if (wb_hit[i])
                        value_ready[i] <= 1'b1;
                    if (br.valid && br.tag == rob_tag_t'(i))
                        br_done[i] <= 1'b1;
                    if (store_done.valid && store_done.tag == rob_tag_t'(i))
                        st_done[i] <= 1'b1;
                end
            end
        end
    end

    // payload
    always_ff @(posedge clk) begin
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            if (alloc_fire && tail_tag == rob_tag_t'(i)) begin
                pc_q[i]       <= alloc.pc;
                dst_addr_q[i] <= alloc.dst_addr;
                dst_wen_q[i]  <= alloc.dst_wen;
                exc_q[i]      <= alloc.exc;
            end
            if (wb_hit[i])
                values[i] <= wb_data[i];
            if (br.valid && br.tag == rob_tag_t'(i)) begin
                br_taken_q[i]  <= br.taken;
                br_target_q[i] <= br.target;
            end
        end
    end

    always_comb begin
        head_entry.busy        = busy[head_tag];
        head_entry.pc          = pc_q[head_tag];
        head_entry.dst_addr    = dst_addr_q[head_tag];
        head_entry.dst_wen     = dst_wen_q[head_tag];
        head_entry.value       = values[head_tag];
        head_entry.value_ready = value_ready[head_tag];
        head_entry.store_done  = st_done[head_tag];
        head_entry.br_done     = br_done[head_tag];
        head_entry.br_taken    = br_taken_q[head_tag];
        head_entry.br_target   = br_target_q[head_tag];
        head_entry.exc         = exc_q[head_tag];
    end

endmodule

// ==== hw/rob/rob_operand_read.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_operand_read
    import rob_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  opnd_req_t             rs1_req,
    input  opnd_req_t             rs2_req,
    input  wb_pkt_t               wb [`NUM_WB_PORTS],
    input  word_t                 values [`ROB_DEPTH],
    input  logic [`ROB_DEPTH-1:0] value_ready,
    output opnd_rsp_t             rs1_rsp,
    output opnd_rsp_t             rs2_rsp
);

    opnd_req_t  req [2];
    opnd_rsp_t  rsp_d [2];
    logic [1:0] rsp_valid;
    word_t      rsp_value [2];

    assign req[0] = rs1_req;
    assign req[1] = rs2_req;

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            rsp_d[s].valid = req[s].valid && value_ready[req[s].tag];
            rsp_d[s].value = values[req[s].tag];
            // bypass overrides the stored copy, lowest port last so it wins
            for (int p = `NUM_WB_PORTS - 1; p >= 0; p--) begin
                if (req[s].valid && wb[p].valid && wb[p].tag == req[s].tag) begin
                    rsp_d[s].valid = 1'b1;
                    rsp_d[s].value = wb[p].data;
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_valid <= '0;
        end else begin
            for (int s = 0; s < 2; s++)
                rsp_valid[s] <= rsp_d[s].valid;
        end
    end

    always_ff @(posedge clk) begin
        for (int s = 0; s < 2; s++)
            rsp_value[s] <= rsp_d[s].value;
    end

    assign rs1_rsp.valid = rsp_valid[0];
    assign rs1_rsp.value = rsp_value[0];
    assign rs2_rsp.valid = rsp_valid[1];
    assign rs2_rsp.value = rsp_value[1];

endmodule

// ==== hw/rob/rob_ptr_ctrl.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_ptr_ctrl
    import rob_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     alloc_valid,
    input  logic     retire,
    input  logic     flush,
    output logic     alloc_fire,
    output rob_tag_t tail_tag,
    output rob_tag_t head_tag,
    output logic     full,
    output logic     empty
);

    rob_ptr_t head;
    rob_ptr_t tail;

    assign head_tag = head[`ROB_TAG_W-1:0];
    assign tail_tag = tail[`ROB_TAG_W-1:0];

    // same index, wrap bits tell full from empty
    assign empty = (head == tail);
    assign full  = (head[`ROB_TAG_W] != tail[`ROB_TAG_W]) && (head_tag == tail_tag);

    // no allocation while full or while younger entries are being squashed
    assign alloc_fire = alloc_valid && !full && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            head <= '0;
            tail <= '0;
        end else begin
            if (retire)
                head <= head + rob_ptr_t'(1);
            if (flush)
                tail <= head + rob_ptr_t'(1);   // lands on the new head
            else if (alloc_fire)
                tail <= tail + rob_ptr_t'(1);
        end
    end

endmodule

// ==== hw/rob/rob_retire.sv ====
`timescale 1ns/1ps

module rob_retire
    import rob_pkg::*;
(
    input  rob_entry_t head_entry,
    input  rob_tag_t   head_tag,
    output logic       retire,
    output logic       flush,
    output commit_t    commit
);

    logic has_exc;
    logic done;
    logic redirect;

    assign has_exc = (head_entry.exc != EXC_NONE);

    // any completion kind, or a decode fault, lets the head go
    assign done = head_entry.busy &&
                  (head_entry.value_ready || head_entry.store_done ||
                   head_entry.br_done || has_exc);

    assign redirect = done && (has_exc || (head_entry.br_done && head_entry.br_taken));

    assign retire = done;
    assign flush  = redirect;

    always_comb begin
        commit.valid       = done;
        commit.tag         = head_tag;
        commit.pc          = head_entry.pc;
        commit.dst_addr    = head_entry.dst_addr;
        commit.dst_wen     = head_entry.dst_wen && !has_exc;   // faulting insn writes nothing
        commit.value       = head_entry.value;
        commit.redirect    = redirect;
        // trap back to the faulting pc, otherwise the branch target
        commit.redirect_pc = has_exc ? head_entry.pc : head_entry.br_target;
        commit.exc         = head_entry.exc;
    end

endmodule

// ==== hw/rob/rob_top.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_top
    import rob_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  alloc_req_t  alloc,
    input  wb_pkt_t     wb [`NUM_WB_PORTS],
    input  br_res_t     br,
    input  store_done_t store_done,
    input  opnd_req_t   rs1_req,
    input  opnd_req_t   rs2_req,
    output rob_tag_t    alloc_tag,
    output logic        full,
    output logic        empty,
    output commit_t     commit,
    output opnd_rsp_t   rs1_rsp,
    output opnd_rsp_t   rs2_rsp
);

    logic                  alloc_fire;
    rob_tag_t              head_tag;
    logic                  retire;
    logic                  flush;
    rob_entry_t            head_entry;
    word_t                 values [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0] value_ready;

    rob_ptr_ctrl u_ptr_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc_valid (alloc.valid),
        .retire      (retire),
        .flush       (flush),
        .alloc_fire  (alloc_fire),
        .tail_tag    (alloc_tag),   // next tag handed out
        .head_tag    (head_tag),
        .full        (full),
        .empty       (empty)
    );

    rob_entry_array u_entry_array (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc       (alloc),
        .alloc_fire  (alloc_fire),
        .tail_tag    (alloc_tag),
        .head_tag    (head_tag),
        .wb          (wb),
        .br          (br),
        .store_done  (store_done),
        .retire      (retire),
        .flush       (flush),
        .head_entry  (head_entry),
        .values      (values),
        .value_ready (value_ready)
    );

    rob_retire u_retire (
        .head_entry (head_entry),
        .head_tag   (head_tag),
        .retire     (retire),
        .flush      (flush),
        .commit     (commit)
    );

    rob_operand_read u_operand_read (
        .clk         (clk),
        .rst_n       (rst_n),
        .rs1_req     (rs1_req),
        .rs2_req     (rs2_req),
        .wb          (wb),
        .values      (values),
        .value_ready (value_ready),
        .rs1_rsp     (rs1_rsp),
        .rs2_rsp     (rs2_rsp)
    );

endmodule

// ==== tests/rob_tests.svh ====
task automatic reset_state();
    int errs;
    errs = errors;
    if (empty !== 1'b1)
        report_mismatch("empty", 32'd1, 32'(empty));
    if (full !== 1'b0)
        report_mismatch("full", 32'd0, 32'(full));
    if (commit.valid !== 1'b0)
        report_mismatch("commit.valid", 32'd0, 32'(commit.valid));
    if (rs1_rsp.valid !== 1'b0)
        report_mismatch("rs1_rsp.valid", 32'd0, 32'(rs1_rsp.valid));
    if (rs2_rsp.valid !== 1'b0)
        report_mismatch("rs2_rsp.valid", 32'd0, 32'(rs2_rsp.valid));
    close_test("reset_state", errs);
endtask

task automatic ooo_completion();
    int       errs;
    rob_tag_t t [4];
    areg_t    dst [4];
    word_t    d0;
    word_t    d3;
    errs = errors;
    for (int i = 0; i < 4; i++)
        dst[i] = areg_t'($random(seed));
    d0 = $random(seed);
    d3 = $random(seed);
    alloc_entry(32'h0000_1000, dst[0], 1'b1, EXC_NONE, t[0]);
    alloc_entry(32'h0000_1004, dst[1], 1'b0, EXC_NONE, t[1]);   // store
    alloc_entry(32'h0000_1008, dst[2], 1'b0, EXC_NONE, t[2]);   // branch
    alloc_entry(32'h0000_100c, dst[3], 1'b1, EXC_NONE, t[3]);

    drive_wb(2, t[3], d3);
    tick();
    br.valid  = 1'b1;
    br.tag    = t[2];
    br.taken  = 1'b0;
    br.target = 32'h0000_2000;
    tick();
    store_done.valid = 1'b1;
    store_done.tag   = t[1];
    tick();
    if (commit.valid !== 1'b0)   // head still waiting
        report_mismatch("commit.valid", 32'd0, 32'(commit.valid));
    drive_wb(1, t[0], d0);
    tick();

    expect_commit(t[0], 32'h0000_1000, dst[0], 1'b1, 1'b1, d0, 1'b0, '0, EXC_NONE);
    tick();
    expect_commit(t[1], 32'h0000_1004, dst[1], 1'b0, 1'b0, '0, 1'b0, '0, EXC_NONE);
    tick();
    expect_commit(t[2], 32'h0000_1008, dst[2], 1'b0, 1'b0, '0, 1'b0, '0, EXC_NONE);
    tick();
    expect_commit(t[3], 32'h0000_100c, dst[3], 1'b1, 1'b1, d3, 1'b0, '0, EXC_NONE);
    tick();
    if (empty !== 1'b1)
        report_mismatch("empty", 32'd1, 32'(empty));
    close_test("ooo_completion", errs);
endtask

task automatic fill_to_full();
    int       errs;
    rob_tag_t first;
    rob_tag_t tag;
    word_t    data [`ROB_DEPTH];
    errs  = errors;
    first = next_tag;
    for (int i = 0; i < `ROB_DEPTH; i++) begin
        data[i] = $random(seed);
        alloc_entry(32'h0000_3000 + 4 * i, areg_t'(i + 1), 1'b1, EXC_NONE, tag);
    end
    if (full !== 1'b1)
        report_mismatch("full", 32'd1, 32'(full));

    alloc.valid = 1'b1;   // ignored while full
    alloc.pc    = 32'h0000_3ffc;
    tick();
    if (alloc_tag !== first)
        report_mismatch("alloc_tag", 32'(first), 32'(alloc_tag));
    if (full !== 1'b1)
        report_mismatch("full", 32'd1, 32'(full));

    // youngest first, so nothing commits before the head completes
    for (int i = `ROB_DEPTH - 1; i >= 0; i--) begin
        drive_wb(i % `NUM_WB_PORTS, first + rob_tag_t'(i), data[i]);
        tick();
    end
    for (int i = 0; i < `ROB_DEPTH; i++) begin
        expect_commit(first + rob_tag_t'(i), 32'h0000_3000 + 4 * i, areg_t'(i + 1),
                      1'b1, 1'b1, data[i], 1'b0, '0, EXC_NONE);
        tick();
    end
    if (empty !== 1'b1)
        report_mismatch("empty", 32'd1, 32'(empty));
    if (full !== 1'b0)
        report_mismatch("full", 32'd0, 32'(full));
    close_test("fill_to_full", errs);
endtask

task automatic operand_lookup();
    int       errs;
    rob_tag_t t [4];
    word_t    v [4];
    errs = errors;
    for (int i = 0; i < 4; i++) begin
        v[i] = $random(seed);
        alloc_entry(32'h0000_4000 + 4 * i, areg_t'(5 + i), 1'b1, EXC_NONE, t[i]);
    end
    drive_wb(0, t[1], v[1]);
    tick();

    rs1_req.valid = 1'b1;   // stored value
    rs1_req.tag   = t[1];
    rs2_req.valid = 1'b1;   // same-cycle bypass
    rs2_req.tag   = t[2];
    drive_wb(2, t[2], v[2]);
    tick();
    if (rs1_rsp.valid !== 1'b1)
        report_mismatch("rs1_rsp.valid", 32'd1, 32'(rs1_rsp.valid));
    if (rs1_rsp.value !== v[1])
        report_mismatch("rs1_rsp.value", v[1], rs1_rsp.value);
    if (rs2_rsp.valid !== 1'b1)
        report_mismatch("rs2_rsp.valid", 32'd1, 32'(rs2_rsp.valid));
    if (rs2_rsp.value !== v[2])
        report_mismatch("rs2_rsp.value", v[2], rs2_rsp.value);

    rs1_req.valid = 1'b1;
    rs1_req.tag   = t[3];
    tick();
    if (rs1_rsp.valid !== 1'b0)
        report_mismatch("rs1_rsp.valid", 32'd0, 32'(rs1_rsp.valid));

    drive_wb(1, t[3], v[3]);
    drive_wb(0, t[0], v[0]);
    tick();
    for (int i = 0; i < 4; i++) begin
        expect_commit(t[i], 32'h0000_4000 + 4 * i, areg_t'(5 + i), 1'b1, 1'b1, v[i],
                      1'b0, '0, EXC_NONE);
        tick();
    end
    if (empty !== 1'b1)
        report_mismatch("empty", 32'd1, 32'(empty));
    close_test("operand_lookup", errs);
endtask

task automatic branch_flush();
    int       errs;
    rob_tag_t b;
    rob_tag_t y [3];
    pc_t      target;
    errs = errors;
    alloc_entry(32'h0000_5000, 5'd1, 1'b0, EXC_NONE, b);
    for (int i = 0; i < 3; i++)
        alloc_entry(32'h0000_5004 + 4 * i, areg_t'(10 + i), 1'b1, EXC_NONE, y[i]);
    for (int i = 0; i < 3; i++)
        drive_wb(i, y[i], $random(seed));
    tick();

    target       = $random(seed);
    target[1:0]  = 2'b00;
    br.valid     = 1'b1;
    br.tag       = b;
    br.taken     = 1'b1;
    br.target    = target;
    tick();
    expect_commit(b, 32'h0000_5000, 5'd1, 1'b0, 1'b0, '0, 1'b1, target, EXC_NONE);
    tick();
    next_tag = b + rob_tag_t'(1);   // tail rewinds past the retired branch
    for (int i = 0; i < 2; i++) begin
        if (empty !== 1'b1)
            report_mismatch("empty", 32'd1, 32'(empty));
        if (commit.valid !== 1'b0)
            report_mismatch("commit.valid", 32'd0, 32'(commit.valid));
        tick();
    end
    if (alloc_tag !== next_tag)
        report_mismatch("alloc_tag", 32'(next_tag), 32'(alloc_tag));
    close_test("branch_flush", errs);
endtask

task automatic decode_exception();
    int       errs;
    rob_tag_t te;
    pc_t      pc;
    errs      = errors;
    pc        = $random(seed);
    pc[1:0]   = 2'b00;
    alloc_entry(pc, 5'd0, 1'b0, EXC_ILLEGAL_INSN, te);
    expect_commit(te, pc, 5'd0, 1'b0, 1'b0, '0, 1'b1, pc, EXC_ILLEGAL_INSN);

    // younger entry arrives in the flush cycle
    alloc.valid    = 1'b1;
    alloc.pc       = pc + 32'd4;
    alloc.dst_addr = 5'd7;
    alloc.dst_wen  = 1'b1;
    alloc.exc      = EXC_NONE;
    tick();
    next_tag = te + rob_tag_t'(1);
    if (empty !== 1'b1)
        report_mismatch("empty", 32'd1, 32'(empty));
    if (commit.valid !== 1'b0)
        report_mismatch("commit.valid", 32'd0, 32'(commit.valid));
    if (alloc_tag !== next_tag)
        report_mismatch("alloc_tag", 32'(next_tag), 32'(alloc_tag));
    tick();
    if (commit.valid !== 1'b0)
        report_mismatch("commit.valid", 32'd0, 32'(commit.valid));
    close_test("decode_exception", errs);
endtask

// ==== tests/rob_tb.sv ====
`timescale 1ns/1ps
`include "rob_settings.svh"

module rob_tb
    import rob_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    // reset plus six short tests stay well under a few hundred cycles
    localparam int MAX_CYCLES = 2000;

    logic        clk;
    logic        rst_n;
    alloc_req_t  alloc;
    wb_pkt_t     wb [`NUM_WB_PORTS];
    br_res_t     br;
    store_done_t store_done;
    opnd_req_t   rs1_req;
    opnd_req_t   rs2_req;
    rob_tag_t    alloc_tag;
    logic        full;
    logic        empty;
    commit_t     commit;
    opnd_rsp_t   rs1_rsp;
    opnd_rsp_t   rs2_rsp;

    int       seed = 60;
    int       errors = 0;
    int       tests_run = 0;
    int       tests_failed = 0;
    int       cycle_count = 0;
    rob_tag_t next_tag;   // model of the tail

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    rob_top DUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc      (alloc),
        .wb         (wb),
        .br         (br),
        .store_done (store_done),
        .rs1_req    (rs1_req),
        .rs2_req    (rs2_req),
        .alloc_tag  (alloc_tag),
        .full       (full),
        .empty      (empty),
        .commit     (commit),
        .rs1_rsp    (rs1_rsp),
        .rs2_rsp    (rs2_rsp)
    );

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, a test stopped making progress", cycle_count);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic clear_strobes();
        alloc = '0;
        for (int p = 0; p < `NUM_WB_PORTS; p++)
            wb[p] = '0;
        br         = '0;
        store_done = '0;
        rs1_req    = '0;
        rs2_req    = '0;
    endtask

    // one clock, strobes drop on the falling edge
    task automatic tick();
        @(negedge clk);
        clear_strobes();
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        errors++;
        $display("** Error at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp_val, act_val);
    endtask

    task automatic note_failure(input string what);
        errors++;
        $display("at %0t: %s", $time, what);
    endtask

    task automatic close_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            tests_failed++;
            $display("%s: FAILED with %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic drive_wb(input int port, input rob_tag_t tag, input word_t data);
        wb[port].valid = 1'b1;
        wb[port].tag   = tag;
        wb[port].data  = data;
    endtask

    task automatic alloc_entry(input pc_t pc, input areg_t dst, input logic wen,
                               input exc_code_e exc, output rob_tag_t tag);
        if (alloc_tag !== next_tag)
            report_mismatch("alloc_tag", 32'(next_tag), 32'(alloc_tag));
        tag            = next_tag;
        alloc.valid    = 1'b1;
        alloc.pc       = pc;
        alloc.dst_addr = dst;
        alloc.dst_wen  = wen;
        alloc.exc      = exc;
        tick();
        next_tag = next_tag + rob_tag_t'(1);
    endtask

    // waits for commit.valid, leaves the retiring edge to the caller
    task automatic expect_commit(input rob_tag_t tag, input pc_t pc, input areg_t dst,
                                 input logic wen, input logic chk_val, input word_t val,
                                 input logic redir, input pc_t rpc, input exc_code_e exc);
        int waited;
        waited = 0;
        while (commit.valid !== 1'b1 && waited < 8) begin
            tick();
            waited++;
        end
        if (commit.valid !== 1'b1) begin
            note_failure($sformatf("no commit appeared for tag %0d", tag));
        end else begin
            if (commit.tag !== tag)
                report_mismatch("commit.tag", 32'(tag), 32'(commit.tag));
            if (commit.pc !== pc)
                report_mismatch("commit.pc", pc, commit.pc);
            if (commit.dst_addr !== dst)
                report_mismatch("commit.dst_addr", 32'(dst), 32'(commit.dst_addr));
            if (commit.dst_wen !== wen)
                report_mismatch("commit.dst_wen", 32'(wen), 32'(commit.dst_wen));
            if (chk_val && commit.value !== val)
                report_mismatch("commit.value", val, commit.value);
            if (commit.redirect !== redir)
                report_mismatch("commit.redirect", 32'(redir), 32'(commit.redirect));
            if (redir && commit.redirect_pc !== rpc)
                report_mismatch("commit.redirect_pc", rpc, commit.redirect_pc);
            if (commit.exc !== exc)
                report_mismatch("commit.exc", 32'(exc), 32'(commit.exc));
        end
    endtask

`include "rob_tests.svh"

    initial begin
        rst_n = 1'b0;
        clear_strobes();
        next_tag = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_state();
        ooo_completion();
        fill_to_full();
        operand_lookup();
        branch_flush();
        decode_exception();

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+common
+incdir+tests
common/rob_pkg.sv
hw/rob/rob_ptr_ctrl.sv
hw/rob/rob_entry_array.sv
hw/rob/rob_retire.sv
hw/rob/rob_operand_read.sv
hw/rob/rob_top.sv
tests/rob_tb.sv
